// ==== Bender.yml ====
package:
  name: sd_fifo_controller

sources:
  # package first, then leaf modules, then the top level
  - verilog/sd_fifo_pkg.sv
  - verilog/sd_async_fifo.sv
  - verilog/sd_fifo_port_monitor.sv
  - verilog/sd_fifo_controller.sv
  - target: simulation
    files:
      - sim/sd_fifo_controller_tb.sv

// ==== sd_fifo_controller.f ====
verilog/sd_fifo_pkg.sv
verilog/sd_async_fifo.sv
verilog/sd_fifo_port_monitor.sv
verilog/sd_fifo_controller.sv
sim/sd_fifo_controller_tb.sv

// ==== sim/sd_fifo_controller_tb.sv ====
`timescale 1ns/1ps

module sd_fifo_controller_tb;

  localparam int DATA_WIDTH    = 32;
  localparam int ADDR_WIDTH    = 4;
  localparam int DEPTH         = 1 << ADDR_WIDTH;
  localparam int RESET_CYCLES  = 3;
  localparam int RANDOM_CYCLES = 400;
  localparam int TOTAL_CYCLES  = RESET_CYCLES + 4 + 2 * (2 * DEPTH + 20) + 2 * 8
                                 + RANDOM_CYCLES + 2 * DEPTH + 20;
  localparam int WATCHDOG_NS   = 4 * TOTAL_CYCLES * 40;

  logic                                 sd_clock = 1'b0;
  logic                                 wishbone_clock = 1'b0;
  logic                                 reset;
  logic [DATA_WIDTH-1:0]                tx_data;
  logic [DATA_WIDTH-1:0]                rx_data;
  logic [3:0]                           en;
  logic [DATA_WIDTH-1:0]                q_tx_out;
  logic [DATA_WIDTH-1:0]                q_rx_out;
  logic [sd_fifo_pkg::STATUS_WIDTH-1:0] status_out;
  logic [1:0]                           tx_busy;
  logic [1:0]                           rx_busy;
  logic [3:0]                           busy_all;

  int                    wb_seed = 32'hc674;
  int                    sd_seed = ~32'hc674; // second stream for the sd side
  logic [DATA_WIDTH-1:0] tx_model[$];
  logic [DATA_WIDTH-1:0] rx_model[$];
  logic [DATA_WIDTH-1:0] tx_head = '0;
  logic [DATA_WIDTH-1:0] rx_head = '0;
  logic [3:0]            prev_en = '0;
  logic [3:0]            exp_err = '0;

  assign busy_all = {rx_busy, tx_busy}; // indexed like enable_in

  sd_fifo_controller #(
    .DATA_WIDTH(DATA_WIDTH),
    .ADDR_WIDTH(ADDR_WIDTH)
  ) UUT (
    .wishbone_clock(wishbone_clock),
    .sd_clock      (sd_clock),
    .reset         (reset),
    .data_tx_in    (tx_data),
    .data_rx_in    (rx_data),
    .enable_in     (en),
    .q_tx_out      (q_tx_out),
    .q_rx_out      (q_rx_out),
    .status_out    (status_out),
    .tx_busy       (tx_busy),
    .rx_busy       (rx_busy)
  );

  always #20 sd_clock = ~sd_clock;
  always #15 wishbone_clock = ~wishbone_clock;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("Fail at %0d ns: %s expected %h actual %h", $time, name, expected, actual);
      $display("*** FAILED ***");
      $fatal(1, "stopping on first error");
    end
  endtask

  task automatic report_failure(input string msg);
    $display("Error at %0d ns: %s", $time, msg);
    $display("*** FAILED ***");
    $fatal(1, "stopping on first error");
  endtask

  function automatic int draw(input bit sd_side);
    if (sd_side)
      draw = $random(sd_seed);
    else
      draw = $random(wb_seed);
  endfunction

  function automatic int full_pos(input int path);
    full_pos = path ? sd_fifo_pkg::ST_RX_FULL : sd_fifo_pkg::ST_TX_FULL;
  endfunction

  function automatic int empty_pos(input int path);
    empty_pos = path ? sd_fifo_pkg::ST_RX_EMPTY : sd_fifo_pkg::ST_TX_EMPTY;
  endfunction

  function automatic int model_size(input int path);
    model_size = path ? rx_model.size() : tx_model.size();
  endfunction

  function automatic int error_pos(input int port);
    case (port)
      0:       error_pos = sd_fifo_pkg::ST_TX_OVERFLOW;
      1:       error_pos = sd_fifo_pkg::ST_TX_UNDERFLOW;
      2:       error_pos = sd_fifo_pkg::ST_RX_OVERFLOW;
      default: error_pos = sd_fifo_pkg::ST_RX_UNDERFLOW;
    endcase
  endfunction

  function automatic string port_name(input int port);
    case (port)
      0:       port_name = "tx_write";
      1:       port_name = "tx_read";
      2:       port_name = "rx_write";
      default: port_name = "rx_read";
    endcase
  endfunction

  // write side of tx is the bus clock, of rx the card clock
  task automatic wait_write_edge(input int path);
    if (path == 0)
      @(negedge wishbone_clock);
    else
      @(negedge sd_clock);
  endtask

  task automatic wait_read_edge(input int path);
    if (path == 0)
      @(negedge sd_clock);
    else
      @(negedge wishbone_clock);
  endtask

  task automatic set_data(input int path);
    if (path == 0)
      tx_data = draw(0);
    else
      rx_data = draw(1);
  endtask

  // busy follows last enable, error is sticky on refused strobes
  task automatic port_checks(input int port, input logic blocked);
    check_value({port_name(port), " busy"}, prev_en[port], busy_all[port]);
    check_value({port_name(port), " error"}, exp_err[port], status_out[error_pos(port)]);
    if (en[port] && blocked)
      exp_err[port] = 1'b1;
    prev_en[port] = en[port];
  endtask

  always @(posedge wishbone_clock)
  begin
    if (!reset)
    begin
      port_checks(0, status_out[sd_fifo_pkg::ST_TX_FULL]);
      if (en[0] && !status_out[sd_fifo_pkg::ST_TX_FULL])
      begin
        if (tx_model.size() == DEPTH)
          report_failure("TX write accepted while the model is full");
        else
          tx_model.push_back(tx_data);
      end
      check_value("q_rx_out", rx_head, q_rx_out);
      port_checks(3, status_out[sd_fifo_pkg::ST_RX_EMPTY]);
      if (en[3] && !status_out[sd_fifo_pkg::ST_RX_EMPTY])
      begin
        if (rx_model.size() == 0)
          report_failure("RX read accepted while the model is empty");
        else
          rx_head = rx_model.pop_front();
      end
    end
  end

  always @(posedge sd_clock)
  begin
    if (!reset)
    begin
      check_value("q_tx_out", tx_head, q_tx_out);
      port_checks(1, status_out[sd_fifo_pkg::ST_TX_EMPTY]);
      if (en[1] && !status_out[sd_fifo_pkg::ST_TX_EMPTY])
      begin
        if (tx_model.size() == 0)
          report_failure("TX read accepted while the model is empty");
        else
          tx_head = tx_model.pop_front();
      end
      port_checks(2, status_out[sd_fifo_pkg::ST_RX_FULL]);
      if (en[2] && !status_out[sd_fifo_pkg::ST_RX_FULL])
      begin
        if (rx_model.size() == DEPTH)
          report_failure("RX write accepted while the model is full");
        else
          rx_model.push_back(rx_data);
      end
    end
  end

  // reads only while empty is low, so no underflow
  task automatic drain(input int path);
    repeat (4) wait_read_edge(path);
    while (!status_out[empty_pos(path)])
    begin
      en[2 * path + 1] = 1'b1;
      wait_read_edge(path);
    end
    en[2 * path + 1] = 1'b0;
    check_value({port_name(2 * path + 1), " words at empty"}, 0, model_size(path));
  endtask

  task automatic overflow_test(input int path);
    wait_write_edge(path);
    while (!status_out[full_pos(path)])
    begin
      en[2 * path] = 1'b1;
      set_data(path);
      wait_write_edge(path);
    end
    check_value({port_name(2 * path), " words at full"}, DEPTH, model_size(path));
    check_value("overflow before write while full", 0, status_out[error_pos(2 * path)]);
    set_data(path); // strobe stays high into a full fifo
    wait_write_edge(path);
    en[2 * path] = 1'b0;
    check_value("overflow after write while full", 1, status_out[error_pos(2 * path)]);
    drain(path);
    wait_write_edge(path);
    check_value("overflow after drain", 1, status_out[error_pos(2 * path)]);
  endtask

  task automatic underflow_test(input int path);
    wait_read_edge(path);
    check_value("empty before underflow", 1, status_out[empty_pos(path)]);
    check_value("underflow before read", 0, status_out[error_pos(2 * path + 1)]);
    en[2 * path + 1] = 1'b1;
    wait_read_edge(path);
    en[2 * path + 1] = 1'b0;
    check_value("underflow after read", 1, status_out[error_pos(2 * path + 1)]);
    repeat (3) wait_read_edge(path);
    check_value("underflow held", 1, status_out[error_pos(2 * path + 1)]);
  endtask

  task automatic random_traffic();
    int wb_r;
    int sd_r;
    fork
      begin
        repeat (RANDOM_CYCLES)
        begin
          @(negedge wishbone_clock);
          wb_r = draw(0);
          en[0] = wb_r[0];
          en[3] = wb_r[1];
          tx_data = draw(0);
        end
        @(negedge wishbone_clock);
        en[0] = 1'b0;
        en[3] = 1'b0;
      end
      begin
        repeat (RANDOM_CYCLES)
        begin
          @(negedge sd_clock);
          sd_r = draw(1);
          en[1] = sd_r[0];
          en[2] = sd_r[1];
          rx_data = draw(1);
        end
        @(negedge sd_clock);
        en[1] = 1'b0;
        en[2] = 1'b0;
      end
    join
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired, the test did not finish in time");
    $display("*** FAILED ***");
    $fatal(1, "timeout");
  end

  initial
  begin
    reset = 1'b1;
    en = '0;
    tx_data = '0;
    rx_data = '0;
    repeat (RESET_CYCLES) @(negedge sd_clock);
    reset = 1'b0;
    @(posedge sd_clock);
    @(negedge sd_clock);
    check_value("q_tx_out", 0, q_tx_out);
    check_value("q_rx_out", 0, q_rx_out);
    check_value("status_out", 8'b0000_1010, status_out); // both empty, nothing else
    check_value("tx_busy", 0, tx_busy);
    check_value("rx_busy", 0, rx_busy);
    overflow_test(0);
    overflow_test(1);
    underflow_test(0);
    underflow_test(1);
    random_traffic();
    fork
      drain(0);
      drain(1);
    join
    repeat (4) @(negedge sd_clock);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== verilog/sd_async_fifo.sv ====
`timescale 1ns/1ps

module sd_async_fifo #(
  parameter int DATA_WIDTH = 32,
  parameter int ADDR_WIDTH = 4
) (
  input  logic                  write_clock,
  input  logic                  read_clock,
  input  logic                  reset,
  input  logic [DATA_WIDTH-1:0] data,
  input  logic                  write_enable,
  input  logic                  read_enable,
  output logic [DATA_WIDTH-1:0] q,
  output logic                  fifo_full,
  output logic                  fifo_empty,
  output logic                  write_accept,
  output logic                  read_accept
);

  localparam int DEPTH = 1 << ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  // write side pointers, one extra bit for wrap
  logic [ADDR_WIDTH:0] wr_bin;
  logic [ADDR_WIDTH:0] wr_gray;
  logic [ADDR_WIDTH:0] wr_bin_next;
  logic [ADDR_WIDTH:0] wr_gray_next;

  // read side pointers
  logic [ADDR_WIDTH:0] rd_bin;
  logic [ADDR_WIDTH:0] rd_gray;
  logic [ADDR_WIDTH:0] rd_bin_next;
  logic [ADDR_WIDTH:0] rd_gray_next;

  // crossing stages
  logic [ADDR_WIDTH:0] wq1_rd_gray;
  logic [ADDR_WIDTH:0] wq2_rd_gray;
  logic [ADDR_WIDTH:0] rq1_wr_gray;
  logic [ADDR_WIDTH:0] rq2_wr_gray;

  assign write_accept = write_enable & ~fifo_full;
  assign read_accept  = read_enable & ~fifo_empty;

  assign wr_bin_next  = wr_bin + {{ADDR_WIDTH{1'b0}}, write_accept};
  assign wr_gray_next = (wr_bin_next >> 1) ^ wr_bin_next;

  assign rd_bin_next  = rd_bin + {{ADDR_WIDTH{1'b0}}, read_accept};
  assign rd_gray_next = (rd_bin_next >> 1) ^ rd_bin_next;

  always_ff @(posedge write_clock or posedge reset)
  begin
    if (reset)
    begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end
    else
    begin
      wr_bin  <= wr_bin_next;
      wr_gray <= wr_gray_next;
    end
  end

  always_ff @(posedge write_clock)
  begin
    if (write_accept)
      mem[wr_bin[ADDR_WIDTH-1:0]] <= data;
  end

  // read pointer into write domain
  always_ff @(posedge write_clock or posedge reset)
  begin
    if (reset)
    begin
      wq1_rd_gray <= '0;
      wq2_rd_gray <= '0;
    end
    else
    begin
      wq1_rd_gray <= rd_gray;
      wq2_rd_gray <= wq1_rd_gray;
    end
  end

  always_ff @(posedge read_clock or posedge reset)
  begin
    if (reset)
    begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end
    else
    begin
      rd_bin  <= rd_bin_next;
      rd_gray <= rd_gray_next;
    end
  end

  // head word, held until next accepted read
  always_ff @(posedge read_clock or posedge reset)
  begin
    if (reset)
      q <= '0;
    else if (read_accept)
      q <= mem[rd_bin[ADDR_WIDTH-1:0]];
  end

  // write pointer into read domain
  always_ff @(posedge read_clock or posedge reset)
  begin
    if (reset)
    begin
      rq1_wr_gray <= '0;
      rq2_wr_gray <= '0;
    end
    else
    begin
      rq1_wr_gray <= wr_gray;
      rq2_wr_gray <= rq1_wr_gray;
    end
  end

  // full when the write side is one lap ahead
  assign fifo_full  = (wr_gray == {~wq2_rd_gray[ADDR_WIDTH:ADDR_WIDTH-1],
                                   wq2_rd_gray[ADDR_WIDTH-2:0]});
  assign fifo_empty = (rq2_wr_gray == rd_gray);

  // true occupancy from both binary pointers
  property p_no_write_while_full;
    @(posedge write_clock) disable iff (reset)
      (wr_bin == {~rd_bin[ADDR_WIDTH], rd_bin[ADDR_WIDTH-1:0]}) |=> $stable(wr_bin);
  endproperty

  property p_no_read_while_empty;
    @(posedge read_clock) disable iff (reset)
      (rd_bin == wr_bin) |=> $stable(rd_bin);
  endproperty

  a_no_write_while_full: assert property (p_no_write_while_full)
    else $error("write pointer advanced while fifo full");

  a_no_read_while_empty: assert property (p_no_read_while_empty)
    else $error("read pointer advanced while fifo empty");

endmodule

// ==== verilog/sd_fifo_controller.sv ====
`timescale 1ns/1ps

module sd_fifo_controller #(
  parameter int DATA_WIDTH = 32,
  parameter int ADDR_WIDTH = 4
) (
  input  logic                                wishbone_clock,
  input  logic                                sd_clock,
  input  logic                                reset,
  input  logic [DATA_WIDTH-1:0]               data_tx_in,
  input  logic [DATA_WIDTH-1:0]               data_rx_in,
  input  logic [3:0]                          enable_in,
  output logic [DATA_WIDTH-1:0]               q_tx_out,
  output logic [DATA_WIDTH-1:0]               q_rx_out,
  output logic [sd_fifo_pkg::STATUS_WIDTH-1:0] status_out,
  output logic [1:0]                          tx_busy,
  output logic [1:0]                          rx_busy
);

  logic tx_write_accept;
  logic tx_read_accept;
  logic rx_write_accept;
  logic rx_read_accept;

  // bus to card
  sd_async_fifo #(
    .DATA_WIDTH(DATA_WIDTH),
    .ADDR_WIDTH(ADDR_WIDTH)
  ) tx_fifo (
    .write_clock (wishbone_clock),
    .read_clock  (sd_clock),
    .reset       (reset),
    .data        (data_tx_in),
    .write_enable(enable_in[0]),
    .read_enable (enable_in[1]),
    .q           (q_tx_out),
    .fifo_full   (status_out[sd_fifo_pkg::ST_TX_FULL]),
    .fifo_empty  (status_out[sd_fifo_pkg::ST_TX_EMPTY]),
    .write_accept(tx_write_accept),
    .read_accept (tx_read_accept)
  );

  // card to bus, write side on sd_clock
  sd_async_fifo #(
    .DATA_WIDTH(DATA_WIDTH),
    .ADDR_WIDTH(ADDR_WIDTH)
  ) rx_fifo (
    .write_clock (sd_clock),
    .read_clock  (wishbone_clock),
    .reset       (reset),
    .data        (data_rx_in),
    .write_enable(enable_in[2]),
    .read_enable (enable_in[3]),
    .q           (q_rx_out),
    .fifo_full   (status_out[sd_fifo_pkg::ST_RX_FULL]),
    .fifo_empty  (status_out[sd_fifo_pkg::ST_RX_EMPTY]),
    .write_accept(rx_write_accept),
    .read_accept (rx_read_accept)
  );

  sd_fifo_port_monitor tx_write_mon (
    .clock (wishbone_clock),
    .reset (reset),
    .enable(enable_in[0]),
    .accept(tx_write_accept),
    .busy  (tx_busy[0]),
    .error (status_out[sd_fifo_pkg::ST_TX_OVERFLOW])
  );

  sd_fifo_port_monitor tx_read_mon (
    .clock (sd_clock),
    .reset (reset),
    .enable(enable_in[1]),
    .accept(tx_read_accept),
    .busy  (tx_busy[1]),
    .error (status_out[sd_fifo_pkg::ST_TX_UNDERFLOW])
  );

  sd_fifo_port_monitor rx_write_mon (
    .clock (sd_clock),
    .reset (reset),
    .enable(enable_in[2]),
    .accept(rx_write_accept),
    .busy  (rx_busy[0]),
    .error (status_out[sd_fifo_pkg::ST_RX_OVERFLOW])
  );

  sd_fifo_port_monitor rx_read_mon (
    .clock (wishbone_clock),
    .reset (reset),
    .enable(enable_in[3]),
    .accept(rx_read_accept),
    .busy  (rx_busy[1]),
    .error (status_out[sd_fifo_pkg::ST_RX_UNDERFLOW])
  );

endmodule

// ==== verilog/sd_fifo_pkg.sv ====
package sd_fifo_pkg;

  // fifo port activity
  typedef enum logic [1:0]
  {
    PORT_RESET  = 2'b00,
    PORT_IDLE   = 2'b01,
    PORT_ACTIVE = 2'b10
  } port_state_e;

  // status_out bit map
  localparam int ST_TX_FULL      = 0;
  localparam int ST_TX_EMPTY     = 1;
  localparam int ST_RX_FULL      = 2;
  localparam int ST_RX_EMPTY     = 3;

  // sticky misuse flags
  localparam int ST_TX_OVERFLOW  = 4;
  localparam int ST_TX_UNDERFLOW = 5;
  localparam int ST_RX_OVERFLOW  = 6;
  localparam int ST_RX_UNDERFLOW = 7;

  localparam int STATUS_WIDTH    = 8;

endpackage

// ==== verilog/sd_fifo_port_monitor.sv ====
`timescale 1ns/1ps

module sd_fifo_port_monitor (
  input  logic clock,
  input  logic reset,
  input  logic enable,
  input  logic accept,
  output logic busy,
  output logic error
);

  sd_fifo_pkg::port_state_e state;
  sd_fifo_pkg::port_state_e next_state;

  always_comb
  begin
    case (state)
      sd_fifo_pkg::PORT_RESET:
      begin
        next_state = sd_fifo_pkg::PORT_IDLE;
      end
      sd_fifo_pkg::PORT_IDLE:
      begin
        if (enable)
          next_state = sd_fifo_pkg::PORT_ACTIVE;
        else
          next_state = sd_fifo_pkg::PORT_IDLE;
      end
      sd_fifo_pkg::PORT_ACTIVE:
      begin
        if (!enable)
          next_state = sd_fifo_pkg::PORT_IDLE; // strobe dropped
        else
          next_state = sd_fifo_pkg::PORT_ACTIVE;
      end
      default:
      begin
        next_state = sd_fifo_pkg::PORT_IDLE;
      end
    endcase
  end

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
      state <= sd_fifo_pkg::PORT_RESET;
    else
      state <= next_state;
  end

  // sticky, enable seen without accept
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
      error <= 1'b0;
    else if (enable && !accept)
      error <= 1'b1;
  end

  assign busy = (state == sd_fifo_pkg::PORT_ACTIVE);

  property p_error_sticky;
    @(posedge clock) disable iff (reset)
      error |=> error;
  endproperty

  a_error_sticky: assert property (p_error_sticky)
    else $error("misuse flag cleared outside reset");

endmodule
